//--- dv/fcta_tb.sv
`timescale 1ns/1ps
`include "fcta_cfg.svh"

module fcta_tb;

    // stimulus plus stalls stays well under 1000 cycles
    localparam int TIMEOUT_CYCLES = 4000;

    logic        clk_i = 1'b0;
    logic        rst_n_i;
    logic        cfg_valid_i;
    logic [15:0] cfg_data_i;
    logic        tvalid_i;
    logic [63:0] tdata_i;
    logic        tready_i;
    logic        cfg_ready_o;
    logic        tready_o;
    logic        tvalid_o;
    logic [63:0] tdata_o;
    logic        tlast_o;

    integer      seed = 67;
    int          errors = 0;
    int          beats_seen = 0;
    int          cycles = 0;
    logic        bp_en = 1'b0;
    logic        job_active;
    // {tlast, tdata} per expected output beat
    logic [64:0] exp_q [$];

    fcta_top dut0 (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cfg_valid_i (cfg_valid_i),
        .cfg_data_i  (cfg_data_i),
        .tvalid_i    (tvalid_i),
        .tdata_i     (tdata_i),
        .tready_i    (tready_i),
        .cfg_ready_o (cfg_ready_o),
        .tready_o    (tready_o),
        .tvalid_o    (tvalid_o),
        .tdata_o     (tdata_o),
        .tlast_o     (tlast_o)
    );

    always #10 clk_i = ~clk_i;

    // reference for one lane: relu, round half-up at bit 13, shift 14, clamp
    function automatic logic [15:0] expect_lane(input logic signed [31:0] acc,
                                                input logic relu_on);
        logic signed [31:0] v;
        logic signed [32:0] r;
        v = (relu_on && acc < 0) ? 32'sd0 : acc;
        r = ($signed({v[31], v}) + 33'sd8192) >>> 14;
        if (r > 33'sd32767)
            return 16'h7fff;
        if (r < -33'sd32768)
            return 16'h8000;
        return r[15:0];
    endfunction

    task automatic send_cfg(input logic [15:0] word);
        @(negedge clk_i);
        cfg_valid_i = 1'b1;
        cfg_data_i  = word;
        #1;
        while (!cfg_ready_o) begin
            @(negedge clk_i);
            #1;
        end
        @(posedge clk_i);
        @(negedge clk_i);
        cfg_valid_i = 1'b0;
        @(posedge clk_i);
    endtask

    // hold the beat until tready_o is seen before a rising edge
    task automatic send_beat(input logic [63:0] d);
        @(negedge clk_i);
        tvalid_i = 1'b1;
        tdata_i  = d;
        #1;
        while (!tready_o) begin
            @(negedge clk_i);
            #1;
        end
        @(posedge clk_i);
    endtask

    // mode 0 small random, 1 negative-biased weights, 2 saturating values
    task automatic run_job(input int n, input int m, input logic relu_on, input int mode);
        logic signed [15:0] xv [16];
        logic signed [15:0] wv [16][4];
        logic signed [31:0] acc [4];
        logic [63:0]        beat;
        logic [63:0]        expd;
        int                 seen0;
        send_cfg(16'((int'(relu_on) << 8) | ((m - 1) << 4) | (n - 1)));
        seen0 = beats_seen;
        for (int s = 0; s < m; s++) begin
            for (int k = 0; k < 16; k++) begin
                xv[k] = 16'($random(seed) % 512);
                if (mode == 1)
                    xv[k] = 16'($random(seed) & 511);
                else if (mode == 2)
                    xv[k] = 16'h4000;
                for (int i = 0; i < 4; i++) begin
                    wv[k][i] = 16'($random(seed) % 8192);
                    if (mode == 1 && i < 2)
                        wv[k][i] = -16'(($random(seed) & 4095) + 1);
                end
                if (mode == 2) begin
                    wv[k][0] = 16'h4000;
                    wv[k][1] = 16'hc000;
                    wv[k][2] = 16'h2000;
                    wv[k][3] = 16'h0100;
                end
            end
            // model sums wrap at 32 bits like the accumulator
            for (int i = 0; i < 4; i++) begin
                acc[i] = '0;
                for (int k = 0; k < n; k++)
                    acc[i] = acc[i] + xv[k] * wv[k][i];
                expd[i*16 +: 16] = expect_lane(acc[i], relu_on);
            end
            exp_q.push_back({(s == m - 1), expd});
            // activations four per beat, unused tail lanes zero
            for (int b = 0; b < (n + 3) / 4; b++) begin
                for (int i = 0; i < 4; i++)
                    beat[i*16 +: 16] = (b * 4 + i < n) ? xv[b*4 + i] : 16'h0;
                send_beat(beat);
            end
            for (int k = 0; k < n; k++) begin
                for (int i = 0; i < 4; i++)
                    beat[i*16 +: 16] = wv[k][i];
                send_beat(beat);
            end
        end
        @(negedge clk_i);
        tvalid_i = 1'b0;
        while (exp_q.size() != 0)
            @(negedge clk_i);
        // config port reopens once the job's last beat has left
        while (!cfg_ready_o)
            @(negedge clk_i);
        @(negedge clk_i);
        assert (beats_seen - seen0 == m && !tvalid_o) else begin
            errors++;
            $display("job n=%0d m=%0d returned %0d beats", n, m, beats_seen - seen0);
        end
    endtask

    // random output stalls only in the back-pressure jobs
    always @(negedge clk_i) begin
        tready_i = bp_en ? $random(seed) & 1 : 1'b1;
    end

    // compare every output transfer with the model queue
    always @(posedge clk_i) begin : check_out
        logic [64:0] e;
        if (rst_n_i && tvalid_o && tready_i) begin
            // every transfer counts, expected or not
            beats_seen++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("output beat at %0t with none expected", $time);
            end else begin
                e = exp_q.pop_front();
                for (int i = 0; i < `FCTA_NUM_PE; i++) begin
                    assert (tdata_o[i*16 +: 16] == e[i*16 +: 16]) else begin
                        errors++;
                        $display("FAILED t=%0t tdata_o lane %0d expected %h got %h",
                                 $time, i, e[i*16 +: 16], tdata_o[i*16 +: 16]);
                    end
                end
                assert (tlast_o == e[64]) else begin
                    errors++;
                    $display("FAILED t=%0t tlast_o expected %b got %b", $time, e[64], tlast_o);
                end
            end
        end
    end

    // job runs from config acceptance to the tlast transfer
    always @(posedge clk_i) begin
        if (!rst_n_i)
            job_active <= 1'b0;
        else if (cfg_valid_i && cfg_ready_o)
            job_active <= 1'b1;
        else if (tvalid_o && tready_i && tlast_o)
            job_active <= 1'b0;
    end

    a_stall_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (tvalid_o && !tready_i) |=> (tvalid_o && $stable(tdata_o) && $stable(tlast_o)))
        else begin
            errors++;
            $display("output beat changed or dropped while stalled at %0t", $time);
        end

    a_cfg_locked: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        job_active |-> !cfg_ready_o)
        else begin
            errors++;
            $display("config port open during a job at %0t", $time);
        end

    a_cfg_reopen: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (tvalid_o && tready_i && tlast_o) |=> cfg_ready_o)
        else begin
            errors++;
            $display("config port did not reopen after the last beat at %0t", $time);
        end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("errors: %0d, beats checked: %0d", errors + 1, beats_seen);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        rst_n_i     = 1'b0;
        cfg_valid_i = 1'b0;
        cfg_data_i  = '0;
        tvalid_i    = 1'b0;
        tdata_i     = '0;
        tready_i    = 1'b1;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        #1;
        assert (cfg_ready_o && !tready_o && !tvalid_o && !tlast_o) else begin
            errors++;
            $display("outputs not in their reset state after reset");
        end
        @(posedge clk_i);
        // identity, full length
        run_job(16, 3, 1'b0, 0);
        // relu with negative lanes
        run_job(8, 4, 1'b1, 1);
        // both saturation limits
        run_job(4, 2, 1'b0, 2);
        // stalled output, partial activation beat
        bp_en = 1'b1;
        run_job(6, 8, 1'b1, 0);
        run_job(1, 1, 1'b0, 0);
        bp_en = 1'b0;
        repeat (4) @(posedge clk_i);
        $display("errors: %0d, beats checked: %0d", errors, beats_seen);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- fcta_top.f
+incdir+src
src/fcta_num_pkg.sv
src/fcta_ctrl_pkg.sv
src/fcta_cfg_regs.sv
src/fcta_input_stage.sv
src/fcta_mac_array.sv
src/fcta_output_stage.sv
src/fcta_top.sv
dv/fcta_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the fcta testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module fcta_tb -f fcta_top.f -o fcta_sim

./obj_dir/fcta_sim | tee sim.log

if grep -q "Finished with errors" sim.log; then
    echo "simulation FAILED, see sim.log"
    exit 1
fi
echo "simulation passed"

//--- src/fcta_cfg.svh
`ifndef FCTA_CFG_SVH
`define FCTA_CFG_SVH

// datapath geometry
`define FCTA_NUM_PE     4
`define FCTA_LANE_BW    16
`define FCTA_BEAT_BW    (`FCTA_NUM_PE * `FCTA_LANE_BW)
// Q10.22 accumulator, 14 fraction bits dropped to reach Q8.8
`define FCTA_ACC_BW     32
`define FCTA_FRAC_DROP  14

// job limits and the counter widths that hold them
`define FCTA_MAX_N      16
`define FCTA_MAX_M      8
`define FCTA_N_BW       5
`define FCTA_M_BW       4

// config word layout
`define FCTA_CFG_BW     16
`define FCTA_N_LSB      0
`define FCTA_N_MSB      3
`define FCTA_M_LSB      4
`define FCTA_M_MSB      6
`define FCTA_ACT_BIT    8

// activation codes
`define FCTA_ACT_IDENT  1'b0
`define FCTA_ACT_RELU   1'b1

`endif

//--- src/fcta_cfg_regs.sv
`timescale 1ns/1ps
`include "fcta_cfg.svh"

module fcta_cfg_regs (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     cfg_valid_i,
    input  logic [`FCTA_CFG_BW-1:0]  cfg_data_i,
    input  logic                     job_done_i,
    output logic                     cfg_ready_o,
    output logic                     job_start_o,
    output logic [`FCTA_N_BW-1:0]    n_o,
    output logic [`FCTA_M_BW-1:0]    m_o,
    output logic                     act_o
);

    logic busy_q;
    logic start_q;
    logic accept;

    // a config beat is taken only while no job runs
    assign cfg_ready_o = !busy_q;
    assign accept      = cfg_valid_i && !busy_q;
    assign job_start_o = start_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q  <= 1'b0;
            start_q <= 1'b0;
        end else begin
            // start pulse lands the cycle after acceptance
            start_q <= accept;
            if (accept)
                busy_q <= 1'b1;
            else if (job_done_i)
                busy_q <= 1'b0;
        end
    end

    // decoded fields, held for the whole job
    always_ff @(posedge clk_i) begin
        if (accept) begin
            n_o   <= fcta_ctrl_pkg::cfg_n(cfg_data_i);
            m_o   <= fcta_ctrl_pkg::cfg_m(cfg_data_i);
            act_o <= fcta_ctrl_pkg::cfg_act(cfg_data_i);
        end
    end

    // a start follows an idle cycle and never meets the done of an earlier job
    a_start_from_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        job_start_o |-> ($past(!busy_q) && !job_done_i));

endmodule

//--- src/fcta_ctrl_pkg.sv
`include "fcta_cfg.svh"

package fcta_ctrl_pkg;

    // input length, field holds n-1
    function automatic logic [`FCTA_N_BW-1:0] cfg_n(input logic [`FCTA_CFG_BW-1:0] cfg);
        return {1'b0, cfg[`FCTA_N_MSB:`FCTA_N_LSB]} + 5'd1;
    endfunction

    // batch size, field holds m-1
    function automatic logic [`FCTA_M_BW-1:0] cfg_m(input logic [`FCTA_CFG_BW-1:0] cfg);
        return {1'b0, cfg[`FCTA_M_MSB:`FCTA_M_LSB]} + 4'd1;
    endfunction

    // activation select, single bit
    function automatic logic cfg_act(input logic [`FCTA_CFG_BW-1:0] cfg);
        return cfg[`FCTA_ACT_BIT];
    endfunction

endpackage

//--- src/fcta_input_stage.sv
`timescale 1ns/1ps
`include "fcta_cfg.svh"

module fcta_input_stage (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     job_start_i,
    input  logic [`FCTA_N_BW-1:0]    n_i,
    input  logic [`FCTA_M_BW-1:0]    m_i,
    input  logic                     tvalid_i,
    input  logic [`FCTA_BEAT_BW-1:0] tdata_i,
    input  logic                     w_ready_i,
    output logic                     tready_o,
    output logic                     w_valid_o,
    output logic [`FCTA_BEAT_BW-1:0] w_lanes_o,
    output logic [`FCTA_LANE_BW-1:0] x_o,
    output logic                     w_last_o
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_ACT  = 2'd1;
    localparam logic [1:0] ST_WGT  = 2'd2;

    logic [1:0]                 state_q;
    logic [`FCTA_N_BW-1:0]      beat_q;
    logic [`FCTA_M_BW-1:0]      sample_q;
    logic [`FCTA_N_BW-1:0]      n_act;
    logic [`FCTA_LANE_BW-1:0]   act_buf [`FCTA_MAX_N];
    fcta_num_pkg::beat_u        beat;
    logic                       w_fire;
    logic                       last_sample;

    // same word, two readings depending on phase
    assign beat = tdata_i;

    // activation beats per sample, ceil(n/4)
    assign n_act       = (n_i + 5'd3) >> 2;
    assign last_sample = (sample_q == m_i - 4'd1);

    // weight phase forwards the stream straight to the MAC
    assign tready_o  = (state_q == ST_ACT) || ((state_q == ST_WGT) && w_ready_i);
    assign w_valid_o = (state_q == ST_WGT) && tvalid_i;
    assign w_lanes_o = beat.wgt;
    assign w_last_o  = (beat_q == n_i - 5'd1);
    // weight beat k meets activation k
    assign x_o       = act_buf[beat_q[$clog2(`FCTA_MAX_N)-1:0]];
    assign w_fire    = w_valid_o && w_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q  <= ST_IDLE;
            beat_q   <= '0;
            sample_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (job_start_i) begin
                        state_q  <= ST_ACT;
                        beat_q   <= '0;
                        sample_q <= '0;
                    end
                end
                ST_ACT: begin
                    if (tvalid_i) begin
                        if (beat_q == n_act - 5'd1) begin
                            state_q <= ST_WGT;
                            beat_q  <= '0;
                        end else begin
                            beat_q <= beat_q + 5'd1;
                        end
                    end
                end
                ST_WGT: begin
                    if (w_fire) begin
                        if (w_last_o) begin
                            beat_q   <= '0;
                            // next sample may load while the MAC result waits
                            state_q  <= last_sample ? ST_IDLE : ST_ACT;
                            sample_q <= sample_q + 4'd1;
                        end else begin
                            beat_q <= beat_q + 5'd1;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // four activations per beat into consecutive buffer slots
    always_ff @(posedge clk_i) begin
        if (state_q == ST_ACT && tvalid_i) begin
            for (int i = 0; i < `FCTA_NUM_PE; i++) begin
                act_buf[beat_q * `FCTA_NUM_PE + i] <= beat.act[i];
            end
        end
    end

    // a new job only ever finds the stream closed and the FSM idle
    a_no_tready_after_job: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        job_start_i |-> ((state_q == ST_IDLE) && !tready_o));

endmodule

//--- src/fcta_mac_array.sv
`timescale 1ns/1ps
`include "fcta_cfg.svh"

module fcta_mac_array (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     act_i,
    input  logic                     w_valid_i,
    input  logic [`FCTA_BEAT_BW-1:0] w_lanes_i,
    input  logic [`FCTA_LANE_BW-1:0] x_i,
    input  logic                     w_last_i,
    input  logic                     r_ready_i,
    output logic                     w_ready_o,
    output logic                     r_valid_o,
    output logic [`FCTA_BEAT_BW-1:0] r_data_o
);

    logic signed [`FCTA_ACC_BW-1:0] acc_q [`FCTA_NUM_PE];
    logic signed [`FCTA_ACC_BW-1:0] prod  [`FCTA_NUM_PE];
    logic signed [`FCTA_ACC_BW-1:0] sum   [`FCTA_NUM_PE];
    logic signed [`FCTA_ACC_BW-1:0] post  [`FCTA_NUM_PE];
    logic [`FCTA_BEAT_BW-1:0]       res;
    logic                           r_valid_q;
    logic                           w_fire;

    // hold off new weights until the result is handed on
    assign w_ready_o = !r_valid_q;
    assign r_valid_o = r_valid_q;
    assign w_fire    = w_valid_i && w_ready_o;

    always_comb begin
        for (int i = 0; i < `FCTA_NUM_PE; i++) begin
            // Q8.8 x Q2.14 is exactly Q10.22
            prod[i] = $signed(x_i) * $signed(w_lanes_i[i*`FCTA_LANE_BW +: `FCTA_LANE_BW]);
            // wraps at 32 bits
            sum[i]  = acc_q[i] + prod[i];
            post[i] = (act_i == `FCTA_ACT_IDENT) ? sum[i] : fcta_num_pkg::relu(sum[i]);
            res[i*`FCTA_LANE_BW +: `FCTA_LANE_BW] = fcta_num_pkg::requant(post[i]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            r_valid_q <= 1'b0;
            for (int i = 0; i < `FCTA_NUM_PE; i++) begin
                acc_q[i] <= '0;
            end
        end else begin
            if (w_fire) begin
                // last beat empties the lanes for the next sample
                for (int i = 0; i < `FCTA_NUM_PE; i++) begin
                    acc_q[i] <= w_last_i ? '0 : sum[i];
                end
            end
            if (w_fire && w_last_i)
                r_valid_q <= 1'b1;
            else if (r_ready_i)
                r_valid_q <= 1'b0;
        end
    end

    // result register, written with the final sum of each sample
    always_ff @(posedge clk_i) begin
        if (w_fire && w_last_i)
            r_data_o <= res;
    end

    // weight beat offered while a result waits stays put until taken
    a_result_blocks_weights: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (w_valid_i && r_valid_o) |=>
            (w_valid_i && $stable(w_lanes_i) && $stable(w_last_i)));

endmodule

//--- src/fcta_num_pkg.sv
`include "fcta_cfg.svh"

package fcta_num_pkg;

    // one stream word, read as Q8.8 activations or as Q2.14 weights
    typedef union packed {
        logic [`FCTA_NUM_PE-1:0][`FCTA_LANE_BW-1:0] act;
        logic [`FCTA_NUM_PE-1:0][`FCTA_LANE_BW-1:0] wgt;
    } beat_u;

    // Q10.22 -> Q8.8 with half-up rounding and saturation
    function automatic logic [`FCTA_LANE_BW-1:0] requant(
        input logic signed [`FCTA_ACC_BW-1:0] acc
    );
        logic signed [`FCTA_ACC_BW:0]                rnd;
        logic signed [`FCTA_ACC_BW-`FCTA_FRAC_DROP:0] shf;
        // one extra bit so the rounding add cannot wrap
        rnd = {acc[`FCTA_ACC_BW-1], acc} + (33'sd1 <<< (`FCTA_FRAC_DROP - 1));
        shf = rnd[`FCTA_ACC_BW:`FCTA_FRAC_DROP];
        if (shf > 32767)
            return 16'h7fff;
        else if (shf < -32768)
            return 16'h8000;
        return shf[`FCTA_LANE_BW-1:0];
    endfunction

    // negative sums clamp to zero
    function automatic logic signed [`FCTA_ACC_BW-1:0] relu(
        input logic signed [`FCTA_ACC_BW-1:0] acc
    );
        return acc[`FCTA_ACC_BW-1] ? '0 : acc;
    endfunction

endpackage

//--- src/fcta_output_stage.sv
`timescale 1ns/1ps
`include "fcta_cfg.svh"

module fcta_output_stage (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic [`FCTA_M_BW-1:0]    m_i,
    input  logic                     r_valid_i,
    input  logic [`FCTA_BEAT_BW-1:0] r_data_i,
    input  logic                     tready_i,
    output logic                     r_ready_o,
    output logic                     tvalid_o,
    output logic [`FCTA_BEAT_BW-1:0] tdata_o,
    output logic                     tlast_o,
    output logic                     job_done_o
);

    logic                  valid_q;
    logic                  last_q;
    logic [`FCTA_M_BW-1:0] cnt_q;
    logic                  r_fire;
    logic                  t_fire;
    logic                  cnt_end;

    // one-entry register, refillable in the cycle it drains
    assign r_ready_o  = !valid_q || tready_i;
    assign r_fire     = r_valid_i && r_ready_o;
    assign t_fire     = valid_q && tready_i;
    assign cnt_end    = (cnt_q == m_i - 4'd1);
    assign tvalid_o   = valid_q;
    assign tlast_o    = last_q;
    assign job_done_o = t_fire && last_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
            cnt_q   <= '0;
        end else if (r_fire) begin
            valid_q <= 1'b1;
            // m-th sample of the job carries tlast
            last_q  <= cnt_end;
            cnt_q   <= cnt_end ? '0 : cnt_q + 4'd1;
        end else if (t_fire) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (r_fire)
            tdata_o <= r_data_i;
    end

    // result offered while the register is full waits unchanged
    a_hold_when_stalled: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (r_valid_i && !r_ready_o) |=> (r_valid_i && $stable(r_data_i)));

endmodule

//--- src/fcta_top.sv
`timescale 1ns/1ps
`include "fcta_cfg.svh"

module fcta_top (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     cfg_valid_i,
    input  logic [`FCTA_CFG_BW-1:0]  cfg_data_i,
    input  logic                     tvalid_i,
    input  logic [`FCTA_BEAT_BW-1:0] tdata_i,
    input  logic                     tready_i,
    output logic                     cfg_ready_o,
    output logic                     tready_o,
    output logic                     tvalid_o,
    output logic [`FCTA_BEAT_BW-1:0] tdata_o,
    output logic                     tlast_o
);

    // job control
    logic                     job_start;
    logic                     job_done;
    logic [`FCTA_N_BW-1:0]    n;
    logic [`FCTA_M_BW-1:0]    m;
    logic                     act;
    // input stage to MAC
    logic                     w_valid;
    logic                     w_ready;
    logic [`FCTA_BEAT_BW-1:0] w_lanes;
    logic [`FCTA_LANE_BW-1:0] x_sel;
    logic                     w_last;
    // MAC to output register
    logic                     r_valid;
    logic                     r_ready;
    logic [`FCTA_BEAT_BW-1:0] r_data;

    fcta_cfg_regs u_cfg_regs (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cfg_valid_i (cfg_valid_i),
        .cfg_data_i  (cfg_data_i),
        .job_done_i  (job_done),
        .cfg_ready_o (cfg_ready_o),
        .job_start_o (job_start),
        .n_o         (n),
        .m_o         (m),
        .act_o       (act)
    );

    fcta_input_stage u_input_stage (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .job_start_i (job_start),
        .n_i         (n),
        .m_i         (m),
        .tvalid_i    (tvalid_i),
        .tdata_i     (tdata_i),
        .w_ready_i   (w_ready),
        .tready_o    (tready_o),
        .w_valid_o   (w_valid),
        .w_lanes_o   (w_lanes),
        .x_o         (x_sel),
        .w_last_o    (w_last)
    );

    fcta_mac_array u_mac_array (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .act_i       (act),
        .w_valid_i   (w_valid),
        .w_lanes_i   (w_lanes),
        .x_i         (x_sel),
        .w_last_i    (w_last),
        .r_ready_i   (r_ready),
        .w_ready_o   (w_ready),
        .r_valid_o   (r_valid),
        .r_data_o    (r_data)
    );

    fcta_output_stage u_output_stage (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .m_i         (m),
        .r_valid_i   (r_valid),
        .r_data_i    (r_data),
        .tready_i    (tready_i),
        .r_ready_o   (r_ready),
        .tvalid_o    (tvalid_o),
        .tdata_o     (tdata_o),
        .tlast_o     (tlast_o),
        .job_done_o  (job_done)
    );

endmodule
